/* tb.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/load_store_unit.sv
verilog/dcache_ctrl.sv
verilog/data_ram.sv
verilog/mem_stage_top.sv
test/mem_stage_checker.sv
test/mem_stage_tb.sv

/* test/mem_stage_checker.sv */
// handshake and RAM write assertions, attached to the memory stage top level through bind
module mem_stage_checker (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              req_i,
    input logic              done_i,
    input logic              ram_req_i,
    input logic              ram_we_i,
    input mem_pkg::byte_en_t ram_be_i
);

    // access in flight, set by req, cleared by done
    logic busy_q;
    // failed assertions so far
    int   fail_cnt = 0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (req_i) begin
            busy_q <= 1'b1;
        end else if (done_i) begin
            busy_q <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////

    // reset holds done low
    done_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !done_i)
        else begin
            $error("done_o high while reset is asserted");
            fail_cnt = fail_cnt + 1;
        end

    // done only answers an earlier request
    done_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |-> busy_q)
        else begin
            $error("done_o pulsed without an outstanding request");
            fail_cnt = fail_cnt + 1;
        end

    // one access in flight
    no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i) req_i |-> !busy_q)
        else begin
            $error("req_i issued while an access was still busy");
            fail_cnt = fail_cnt + 1;
        end

    // a RAM write touches at least one lane
    ram_write_be: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                   (ram_req_i && ram_we_i) |-> (ram_be_i != '0))
        else begin
            $error("RAM write issued with all byte enables clear");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind mem_stage_top mem_stage_checker i_mem_stage_checker (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .done_i    (done_o),
    .ram_req_i (ram_req),
    .ram_we_i  (ram_we),
    .ram_be_i  (ram_be)
);

/* test/mem_stage_tb.sv */
// memory stage testbench that runs directed and random accesses against a byte model
`include "mem_cfg.svh"

module mem_stage_tb;

    ////////////////////////////////////////
    // run length
    ////////////////////////////////////////

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 10;
    localparam int RAND_OPS   = 300;
    // word, lane-merge, extension, write-through, prefill, random
    localparam int N_ACCESS   = 24 + 10 + 34 + 12 + 8 + RAND_OPS;
    // worst-case access plus the gap before the next request
    localparam int WATCHDOG_CYCLES = N_ACCESS * (`RAM_LAT + 3 + 2) + RST_CYCLES + 100;

    logic             clk_i = 1'b0;
    logic             rst_n_i;
    logic             req_i;
    mem_pkg::lsu_op_t op_i;
    mem_pkg::addr_t   addr_i;
    mem_pkg::word_t   wdata_i;
    logic             done_o;
    mem_pkg::word_t   load_data_o;

    // byte-wide reference memory
    logic [7:0] ref_mem [1 << `ADDR_W];

    // expectations in issue order
    mem_pkg::word_t exp_q  [$];
    string          name_q [$];
    bit             chk_q  [$];

    // colliding addresses share indexes and differ in tag
    logic [9:0] rand_tags [4] = '{10'h021, 10'h0a4, 10'h1c7, 10'h3f0};
    logic [3:0] rand_idxs [2] = '{4'h3, 4'hb};
    mem_pkg::lsu_op_t rand_ops [8] = '{`LSU_LB, `LSU_LH, `LSU_LW, `LSU_LBU,
                                       `LSU_LHU, `LSU_SB, `LSU_SH, `LSU_SW};
    mem_pkg::lsu_op_t lane_ops [4] = '{`LSU_LB, `LSU_LBU, `LSU_LH, `LSU_LHU};

    mem_stage_top i_mem_stage_top (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .done_o      (done_o),
        .load_data_o (load_data_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // little-endian lanes with halfword and word addresses aligned down
    function automatic mem_pkg::word_t expected_load(input mem_pkg::lsu_op_t op,
                                                     input mem_pkg::addr_t addr);
        mem_pkg::addr_t h;
        mem_pkg::addr_t w;
        logic [7:0]     b;
        logic [15:0]    hv;
        mem_pkg::word_t r;
        h  = {addr[`ADDR_W-1:1], 1'b0};
        w  = {addr[`ADDR_W-1:2], 2'b00};
        b  = ref_mem[addr];
        hv = {ref_mem[h + 1], ref_mem[h]};
        case (op)
            `LSU_LB:  r = {{24{b[7]}}, b};
            `LSU_LBU: r = {24'b0, b};
            `LSU_LH:  r = {{16{hv[15]}}, hv};
            `LSU_LHU: r = {16'b0, hv};
            `LSU_LW:  r = {ref_mem[w + 3], ref_mem[w + 2], ref_mem[w + 1], ref_mem[w]};
            default:  r = '0;
        endcase
        return r;
    endfunction

    task automatic update_ref(input mem_pkg::lsu_op_t op, input mem_pkg::addr_t addr,
                              input mem_pkg::word_t wdata);
        mem_pkg::addr_t h;
        mem_pkg::addr_t w;
        h = {addr[`ADDR_W-1:1], 1'b0};
        w = {addr[`ADDR_W-1:2], 2'b00};
        case (op)
            `LSU_SB: ref_mem[addr] = wdata[7:0];
            `LSU_SH: begin
                ref_mem[h]     = wdata[7:0];
                ref_mem[h + 1] = wdata[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[w + i] = wdata[i*8 +: 8];
                end
            end
        endcase
    endtask

    ////////////////////////////////////////
    // failure path and checks
    ////////////////////////////////////////

    task automatic fail_run();
        $display("Result: FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_val(input string name, input mem_pkg::word_t exp,
                             input mem_pkg::word_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    // one access with its expectation queued before the strobe
    task automatic do_access(input string name, input mem_pkg::lsu_op_t op,
                             input mem_pkg::addr_t addr, input mem_pkg::word_t wdata);
        @(negedge clk_i);
        name_q.push_back(name);
        chk_q.push_back(!op[3]);
        exp_q.push_back(expected_load(op, addr));
        if (op[3]) begin
            update_ref(op, addr, wdata);
        end
        req_i   = 1'b1;
        op_i    = op;
        addr_i  = addr;
        wdata_i = wdata;
        @(negedge clk_i);
        req_i = 1'b0;
        do begin
            @(negedge clk_i);
        end while (!done_o);
    endtask

    // compare at each done and watch the bound checker
    always @(negedge clk_i) begin
        if (i_mem_stage_top.i_mem_stage_checker.fail_cnt != 0) begin
            $display("a checker assertion failed, see the error above");
            fail_run();
        end else if (done_o) begin
            if (exp_q.size() == 0) begin
                $display("done_o pulsed with no access outstanding");
                fail_run();
            end else if (chk_q.pop_front()) begin
                check_val(name_q.pop_front(), exp_q.pop_front(), load_data_o);
            end else begin
                void'(name_q.pop_front());
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: accesses did not finish within %0d cycles", WATCHDOG_CYCLES);
        fail_run();
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        mem_pkg::addr_t   a;
        mem_pkg::word_t   d;
        mem_pkg::lsu_op_t op;
        void'($urandom(32'h5952));
        rst_n_i = 1'b0;
        req_i   = 1'b0;
        op_i    = `LSU_LW;
        addr_i  = '0;
        wdata_i = '0;
        repeat (RST_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;

        // idle after reset
        repeat (4) begin
            @(negedge clk_i);
            check_val("idle_done", '0, mem_pkg::word_t'(done_o));
            check_val("idle_data", '0, load_data_o);
        end

        // word store, miss load, hit load
        for (int i = 0; i < 8; i++) begin
            a = mem_pkg::addr_t'(16'h0400 + i * 68);
            do_access("word_store", `LSU_SW, a, $urandom);
            do_access("word_miss", `LSU_LW, a, '0);
            do_access("word_hit", `LSU_LW, a, '0);
        end

        // sub-word stores merged into one word
        for (int i = 0; i < 2; i++) begin
            a = mem_pkg::addr_t'(16'h2000 + i * 16'h0104);
            do_access("merge_base", `LSU_SW, a, $urandom);
            do_access("merge_sb1", `LSU_SB, a + 1, $urandom);
            do_access("merge_sh2", `LSU_SH, a + 2, $urandom);
            do_access("merge_sb3", `LSU_SB, a + 3, $urandom);
            do_access("merge_lw", `LSU_LW, a, '0);
        end

        // sign and zero extension at every lane offset
        do_access("ext_base0", `LSU_SW, 16'h3000, 32'h80f17fa5);
        do_access("ext_base1", `LSU_SW, 16'h3044, 32'hc3e85a9c);
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 4; k++) begin
                    a = mem_pkg::addr_t'(16'h3000 + w * 16'h44 + off);
                    do_access($sformatf("ext_w%0d_off%0d_op%0h", w, off, lane_ops[k]),
                              lane_ops[k], a, '0);
                end
            end
        end

        // store hits keep the cached line current
        for (int i = 0; i < 2; i++) begin
            a = mem_pkg::addr_t'(16'h4010 + i * 16'h0114);
            do_access("wt_base", `LSU_SW, a, $urandom);
            do_access("wt_fill", `LSU_LW, a, '0);
            do_access("wt_sb", `LSU_SB, a + 2, $urandom);
            do_access("wt_reload_b", `LSU_LW, a, '0);
            do_access("wt_sh", `LSU_SH, a, $urandom);
            do_access("wt_reload_h", `LSU_LW, a, '0);
        end

        // random mix over colliding lines after the region is written
        for (int t = 0; t < 4; t++) begin
            for (int k = 0; k < 2; k++) begin
                do_access("rand_prefill", `LSU_SW, {rand_tags[t], rand_idxs[k], 2'b00}, $urandom);
            end
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            op = rand_ops[$urandom_range(0, 7)];
            a  = {rand_tags[$urandom_range(0, 3)], rand_idxs[$urandom_range(0, 1)],
                  2'($urandom_range(0, 3))};
            d  = $urandom;
            do_access($sformatf("rand_%0d", i), op, a, d);
        end

        // let the last compare retire
        repeat (3) @(negedge clk_i);
        if (exp_q.size() == 0 && i_mem_stage_top.i_mem_stage_checker.fail_cnt == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("accesses left without a done strobe or a checker assertion failed");
            fail_run();
        end
    end

endmodule

/* verilog/data_ram.sv */
// backing word memory with byte-enabled writes, answers every request after RAM_LAT cycles
`include "mem_cfg.svh"

module data_ram (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                ram_req_i,
    input  logic                ram_we_i,
    input  mem_pkg::word_addr_t ram_addr_i,
    input  mem_pkg::byte_en_t   ram_be_i,
    input  mem_pkg::word_t      ram_wdata_i,
    output logic                ram_ack_o,
    output mem_pkg::word_t      ram_rdata_o
);

    // delay stages before the access register
    localparam int DLY = `RAM_LAT - 1;

    mem_pkg::word_t      mem [`RAM_WORDS];

    // request pipeline
    logic [DLY-1:0]      vld_sr;
    logic                we_sr    [DLY];
    mem_pkg::word_addr_t addr_sr  [DLY];
    mem_pkg::byte_en_t   be_sr    [DLY];
    mem_pkg::word_t      wdata_sr [DLY];

    // valid bits and ack
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_sr    <= '0;
            ram_ack_o <= 1'b0;
        end else begin
            vld_sr[0] <= ram_req_i;
            for (int s = 1; s < DLY; s++) begin
                vld_sr[s] <= vld_sr[s-1];
            end
            ram_ack_o <= vld_sr[DLY-1];
        end
    end

    // payload shift and the access itself
    always_ff @(posedge clk_i) begin
        we_sr[0]    <= ram_we_i;
        addr_sr[0]  <= ram_addr_i;
        be_sr[0]    <= ram_be_i;
        wdata_sr[0] <= ram_wdata_i;
        for (int s = 1; s < DLY; s++) begin
            we_sr[s]    <= we_sr[s-1];
            addr_sr[s]  <= addr_sr[s-1];
            be_sr[s]    <= be_sr[s-1];
            wdata_sr[s] <= wdata_sr[s-1];
        end
        // last stage, lands with the ack
        if (vld_sr[DLY-1]) begin
            if (we_sr[DLY-1]) begin
                for (int b = 0; b < `DATA_W/8; b++) begin
                    if (be_sr[DLY-1][b]) begin
                        mem[addr_sr[DLY-1]][b*8 +: 8] <= wdata_sr[DLY-1][b*8 +: 8];
                    end
                end
            end else begin
                ram_rdata_o <= mem[addr_sr[DLY-1]];
            end
        end
    end

endmodule

/* verilog/dcache_ctrl.sv */
// direct-mapped write-through data cache with one-word lines, sits between the LSU and the RAM
`include "mem_cfg.svh"

module dcache_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // from the load/store unit
    input  logic                cache_req_i,
    input  logic                cache_we_i,
    input  mem_pkg::word_addr_t cache_addr_i,
    input  mem_pkg::byte_en_t   cache_be_i,
    input  mem_pkg::word_t      cache_wdata_i,
    // from the RAM
    input  logic                ram_ack_i,
    input  mem_pkg::word_t      ram_rdata_i,
    // to the load/store unit
    output logic                cache_stall_o,
    output logic                cache_rvalid_o,
    output mem_pkg::word_t      cache_rdata_o,
    // to the RAM
    output logic                ram_req_o,
    output logic                ram_we_o,
    output mem_pkg::word_addr_t ram_addr_o,
    output mem_pkg::byte_en_t   ram_be_o,
    output mem_pkg::word_t      ram_wdata_o
);

    ////////////////////////////////////////
    // declarations
    ////////////////////////////////////////

    localparam int LINES = 1 << `IDX_W;
    // word address bits above the index
    localparam int TAG_W = `ADDR_W - 2 - `IDX_W;

    // line storage
    mem_pkg::word_t      data_arr [LINES];
    logic [TAG_W-1:0]    tag_arr  [LINES];
    logic [LINES-1:0]    valid_q;

    // captured request
    logic                we_q;
    mem_pkg::word_addr_t addr_q;
    mem_pkg::byte_en_t   be_q;
    mem_pkg::word_t      wdata_q;

    // word returned by a refill
    mem_pkg::word_t      fill_q;

    mem_pkg::cache_state_t state_q;
    mem_pkg::cache_state_t state_d;

    logic [`IDX_W-1:0]   idx;
    logic [TAG_W-1:0]    tag;
    logic                hit;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    assign idx = addr_q[`IDX_W-1:0];
    assign tag = addr_q[`ADDR_W-3:`IDX_W];
    assign hit = valid_q[idx] && (tag_arr[idx] == tag);

    // busy from the cycle after the strobe
    assign cache_stall_o  = (state_q != mem_pkg::IDLE);

    // load hit answers in LOOKUP, everything else in RESP
    assign cache_rvalid_o = ((state_q == mem_pkg::LOOKUP) && !we_q && hit)
                          || (state_q == mem_pkg::RESP);
    assign cache_rdata_o  = (state_q == mem_pkg::RESP) ? fill_q : data_arr[idx];

    // RAM is used by every store and by a read miss
    assign ram_req_o   = (state_q == mem_pkg::LOOKUP) && (we_q || !hit);
    assign ram_we_o    = we_q;
    assign ram_addr_o  = addr_q;
    assign ram_be_o    = be_q;
    assign ram_wdata_o = wdata_q;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::IDLE: begin
                if (cache_req_i) begin
                    state_d = mem_pkg::LOOKUP;
                end
            end
            mem_pkg::LOOKUP: begin
                if (we_q) begin
                    state_d = mem_pkg::WRITE_THRU;
                end else if (hit) begin
                    state_d = mem_pkg::IDLE;
                end else begin
                    state_d = mem_pkg::REFILL;
                end
            end
            // both RAM waits end on the ack
            mem_pkg::REFILL, mem_pkg::WRITE_THRU: begin
                if (ram_ack_i) begin
                    state_d = mem_pkg::RESP;
                end
            end
            default: begin
                state_d = mem_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= mem_pkg::IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            // refilled line becomes valid
            if ((state_q == mem_pkg::REFILL) && ram_ack_i) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // request capture and arrays
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if ((state_q == mem_pkg::IDLE) && cache_req_i) begin
            we_q    <= cache_we_i;
            addr_q  <= cache_addr_i;
            be_q    <= cache_be_i;
            wdata_q <= cache_wdata_i;
        end
        // store hit: merge enabled lanes, miss leaves the line alone
        if ((state_q == mem_pkg::LOOKUP) && we_q && hit) begin
            for (int b = 0; b < `DATA_W/8; b++) begin
                if (be_q[b]) begin
                    data_arr[idx][b*8 +: 8] <= wdata_q[b*8 +: 8];
                end
            end
        end
        // read miss installs the RAM word
        if ((state_q == mem_pkg::REFILL) && ram_ack_i) begin
            data_arr[idx] <= ram_rdata_i;
            tag_arr[idx]  <= tag;
            fill_q        <= ram_rdata_i;
        end
    end

endmodule

/* verilog/load_store_unit.sv */
// load/store unit: turns an execute-stage request into a cache access and formats load results
`include "mem_cfg.svh"

module load_store_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // request from execute
    input  logic                req_i,
    input  mem_pkg::lsu_op_t    op_i,
    input  mem_pkg::addr_t      addr_i,
    input  mem_pkg::word_t      wdata_i,
    // cache answers
    input  logic                cache_stall_i,
    input  logic                cache_rvalid_i,
    input  mem_pkg::word_t      cache_rdata_i,
    // cache request
    output logic                cache_req_o,
    output logic                cache_we_o,
    output mem_pkg::word_addr_t cache_addr_o,
    output mem_pkg::byte_en_t   cache_be_o,
    output mem_pkg::word_t      cache_wdata_o,
    // result to execute
    output logic                done_o,
    output mem_pkg::word_t      load_data_o
);

    ////////////////////////////////////////
    // declarations
    ////////////////////////////////////////

    // latched for the response
    mem_pkg::lsu_op_t op_q;
    logic [1:0]       off_q;

    // lane extraction
    logic [7:0]       byte_v;
    logic [15:0]      half_v;
    mem_pkg::word_t   load_v;

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////

    // strobes during a stall are dropped, nothing is queued
    assign cache_req_o  = req_i & ~cache_stall_i;
    // op bit 3 marks a store
    assign cache_we_o   = op_i[3];
    assign cache_addr_o = addr_i[`ADDR_W-1:2];

    // byte enables and lane replication
    always_comb begin
        case (op_i)
            `LSU_LB, `LSU_LBU, `LSU_SB: begin
                // one-hot on address bits 1..0
                cache_be_o    = mem_pkg::byte_en_t'(4'b0001 << addr_i[1:0]);
                cache_wdata_o = {4{wdata_i[7:0]}};
            end
            `LSU_LH, `LSU_LHU, `LSU_SH: begin
                // upper or lower pair, bit 0 ignored
                cache_be_o    = addr_i[1] ? 4'b1100 : 4'b0011;
                cache_wdata_o = {2{wdata_i[15:0]}};
            end
            default: begin
                cache_be_o    = 4'b1111;
                cache_wdata_o = wdata_i;
            end
        endcase
    end

    // op and offset held until the answer returns
    always_ff @(posedge clk_i) begin
        if (cache_req_o) begin
            op_q  <= op_i;
            off_q <= addr_i[1:0];
        end
    end

    ////////////////////////////////////////
    // response side
    ////////////////////////////////////////

    // pick the addressed byte and halfword
    assign byte_v = cache_rdata_i[{off_q, 3'b000} +: 8];
    assign half_v = cache_rdata_i[{off_q[1], 4'b0000} +: 16];

    always_comb begin
        case (op_q)
            `LSU_LB:  load_v = {{24{byte_v[7]}}, byte_v};
            `LSU_LBU: load_v = {24'b0, byte_v};
            `LSU_LH:  load_v = {{16{half_v[15]}}, half_v};
            `LSU_LHU: load_v = {16'b0, half_v};
            `LSU_LW:  load_v = cache_rdata_i;
            // stores return nothing
            default:  load_v = '0;
        endcase
    end

    // done one cycle after rvalid
    // data is zero outside the done cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_o      <= 1'b0;
            load_data_o <= '0;
        end else begin
            done_o      <= cache_rvalid_i;
            load_data_o <= cache_rvalid_i ? load_v : '0;
        end
    end

endmodule

/* verilog/mem_cfg.svh */
// widths, latency and load/store op codes for the memory stage, included by the package and RTL
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

////////////////////////////////////////
// datapath sizes
////////////////////////////////////////

// data word width in bits
`define DATA_W 32
// byte address width
`define ADDR_W 16
// cache index bits, 16 lines of one word
`define IDX_W 4
// backing memory depth in words
`define RAM_WORDS 16384
// cycles from RAM request to RAM ack
`define RAM_LAT 3

////////////////////////////////////////
// load/store op codes
////////////////////////////////////////

// bit 3 store, bit 2 unsigned, bits 1..0 size
`define LSU_LB  4'b0000
`define LSU_LH  4'b0001
`define LSU_LW  4'b0010
`define LSU_LBU 4'b0100
`define LSU_LHU 4'b0101
`define LSU_SB  4'b1000
`define LSU_SH  4'b1001
`define LSU_SW  4'b1010

`endif

/* verilog/mem_pkg.sv */
// shared types for the memory stage, referenced by scoped name from the RTL and testbench
`include "mem_cfg.svh"

package mem_pkg;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    // one data word
    typedef logic [`DATA_W-1:0] word_t;

    // byte address as seen by the execute stage
    typedef logic [`ADDR_W-1:0] addr_t;

    // word address between cache and RAM
    // low two byte-offset bits dropped
    typedef logic [`ADDR_W-3:0] word_addr_t;

    // one enable per byte lane
    typedef logic [`DATA_W/8-1:0] byte_en_t;

    // load/store operation code
    typedef logic [3:0] lsu_op_t;

    ////////////////////////////////////////
    // cache controller FSM
    ////////////////////////////////////////

    // IDLE        waiting for a strobe
    // LOOKUP      tag compare, hit answers here
    // REFILL      read miss waits on the RAM
    // WRITE_THRU  store waits on the RAM
    // RESP        answer after a RAM access
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        WRITE_THRU,
        RESP
    } cache_state_t;

endpackage

/* verilog/mem_stage_top.sv */
// memory-access stage as the execute stage sees it: LSU, data cache and backing RAM
module mem_stage_top (
    input  logic             clk_i,
    input  logic             rst_n_i,
    // one access at a time, wait for done
    input  logic             req_i,
    input  mem_pkg::lsu_op_t op_i,
    input  mem_pkg::addr_t   addr_i,
    input  mem_pkg::word_t   wdata_i,
    output logic             done_o,
    output mem_pkg::word_t   load_data_o
);

    ////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////

    // lsu <-> cache
    logic                cache_req;
    logic                cache_we;
    mem_pkg::word_addr_t cache_addr;
    mem_pkg::byte_en_t   cache_be;
    mem_pkg::word_t      cache_wdata;
    logic                cache_stall;
    logic                cache_rvalid;
    mem_pkg::word_t      cache_rdata;

    // cache <-> ram
    logic                ram_req;
    logic                ram_we;
    mem_pkg::word_addr_t ram_addr;
    mem_pkg::byte_en_t   ram_be;
    mem_pkg::word_t      ram_wdata;
    logic                ram_ack;
    mem_pkg::word_t      ram_rdata;

    load_store_unit i_load_store_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .op_i           (op_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .cache_stall_i  (cache_stall),
        .cache_rvalid_i (cache_rvalid),
        .cache_rdata_i  (cache_rdata),
        .cache_req_o    (cache_req),
        .cache_we_o     (cache_we),
        .cache_addr_o   (cache_addr),
        .cache_be_o     (cache_be),
        .cache_wdata_o  (cache_wdata),
        .done_o         (done_o),
        .load_data_o    (load_data_o)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .cache_req_i    (cache_req),
        .cache_we_i     (cache_we),
        .cache_addr_i   (cache_addr),
        .cache_be_i     (cache_be),
        .cache_wdata_i  (cache_wdata),
        .ram_ack_i      (ram_ack),
        .ram_rdata_i    (ram_rdata),
        .cache_stall_o  (cache_stall),
        .cache_rvalid_o (cache_rvalid),
        .cache_rdata_o  (cache_rdata),
        .ram_req_o      (ram_req),
        .ram_we_o       (ram_we),
        .ram_addr_o     (ram_addr),
        .ram_be_o       (ram_be),
        .ram_wdata_o    (ram_wdata)
    );

    data_ram i_data_ram (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ram_req_i   (ram_req),
        .ram_we_i    (ram_we),
        .ram_addr_i  (ram_addr),
        .ram_be_i    (ram_be),
        .ram_wdata_i (ram_wdata),
        .ram_ack_o   (ram_ack),
        .ram_rdata_o (ram_rdata)
    );

endmodule
